// ==== dv/tcdm_golden.txt ====
// columns: seq master rd(1)/wr(0) addr wdata be expected_rdata, all hex
// records with the same seq are driven in the same cycle, ffffffff ends the file
00 0 0 0000001c 0badcafe f 00000000
00 1 0 0000002c 12345678 f 00000000
01 0 0 0000003c 87654321 f 00000000
02 0 1 0000001c 00000000 0 0badcafe
02 1 1 0000002c 00000000 0 12345678
03 0 0 00000010 11223344 f 00000000
04 0 1 00000010 00000000 0 11223344
05 1 0 00000024 a5a5a5a5 f 00000000
06 1 0 00000024 5a5a5a5a 5 00000000
07 1 1 00000024 00000000 0 a55aa55a
08 2 0 00000100 c0000000 f 00000000
09 2 0 00000104 c0000001 f 00000000
0a 2 0 00000108 c0000002 f 00000000
0b 2 0 0000010c c0000003 f 00000000
0c 0 1 00000104 00000000 0 c0000001
0c 3 1 00000108 00000000 0 c0000002
0d 3 1 f0000010 00000000 0 11223344
0e 1 1 00000100 00000000 0 c0000000
0e 2 1 00000010 00000000 0 11223344
0e 3 1 00000100 00000000 0 c0000000
0f 0 1 00000100 00000000 0 c0000000
0f 1 1 00000104 00000000 0 c0000001
0f 2 1 00000108 00000000 0 c0000002
0f 3 1 0000010c 00000000 0 c0000003
ffffffff 0 0 00000000 00000000 0 00000000

// ==== flist.f ====
common/tcdm_pkg.sv
common/tcdm_bank_if.sv
logic/tcdm_addr_decoder.sv
tcdm_xbar/tcdm_bank_arbiter.sv
tcdm_xbar/tcdm_resp_router.sv
tcdm_xbar/tcdm_interconnect.sv
dv/tcdm_sram_model.sv
dv/tcdm_interconnect_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the tcdm interconnect testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tcdm_interconnect_tb -o tcdm_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tcdm_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== dv/tcdm_interconnect_tb.sv ====
// testbench of the tcdm interconnect, replays the golden sequences and checks grants and responses
`timescale 1ns/1ns

module tcdm_interconnect_tb;

  import tcdm_pkg::*;

  localparam int NB_MASTERS = 4;
  localparam int NB_BANKS   = 4;

  logic clk;
  logic rst_n;

  logic  [NB_MASTERS-1:0] req;
  addr_t [NB_MASTERS-1:0] add;
  logic  [NB_MASTERS-1:0] wen;
  data_t [NB_MASTERS-1:0] wdata;
  be_t   [NB_MASTERS-1:0] be;
  logic  [NB_MASTERS-1:0] gnt;
  logic  [NB_MASTERS-1:0] r_valid;
  data_t [NB_MASTERS-1:0] r_rdata;

  logic      [NB_BANKS-1:0] bank_req;
  mem_addr_t [NB_BANKS-1:0] bank_add;
  logic      [NB_BANKS-1:0] bank_wen;
  data_t     [NB_BANKS-1:0] bank_wdata;
  be_t       [NB_BANKS-1:0] bank_be;
  data_t     [NB_BANKS-1:0] bank_rdata;

  // seven words per record, see the header of the golden file
  data_t golden [0:255];

  // requests of the running sequence and responses still owed
  logic  [NB_MASTERS-1:0] pend;
  addr_t [NB_MASTERS-1:0] cur_add;
  logic  [NB_MASTERS-1:0] cur_wen;
  data_t [NB_MASTERS-1:0] cur_wdata;
  be_t   [NB_MASTERS-1:0] cur_be;
  data_t [NB_MASTERS-1:0] cur_exp;
  logic  [NB_MASTERS-1:0] prev_acc;
  logic  [NB_MASTERS-1:0] prev_rd;
  data_t [NB_MASTERS-1:0] prev_exp;
  int                     rr_ptr [NB_BANKS];

  tcdm_interconnect #(
    .NB_MASTERS (NB_MASTERS),
    .NB_BANKS   (NB_BANKS)
  ) UUT (
    .clk_i (clk), .rst_ni (rst_n),
    .req_i (req), .add_i (add), .wen_i (wen), .wdata_i (wdata), .be_i (be),
    .gnt_o (gnt), .r_valid_o (r_valid), .r_rdata_o (r_rdata),
    .bank_req_o (bank_req), .bank_add_o (bank_add), .bank_wen_o (bank_wen),
    .bank_wdata_o (bank_wdata), .bank_be_o (bank_be), .bank_rdata_i (bank_rdata)
  );

  tcdm_sram_model #(.NB_BANKS(NB_BANKS)) u_sram (
    .clk_i (clk), .req_i (bank_req), .add_i (bank_add), .wen_i (bank_wen),
    .wdata_i (bank_wdata), .be_i (bank_be), .rdata_o (bank_rdata)
  );

  always #20 clk = ~clk;

  // **************************************************
  // reference rules
  // **************************************************

  // word interleaving, bank index right above the byte offset
  function automatic int bank_of(input addr_t a);
    return int'((a >> WORD_OFFSET_BITS) % addr_t'(NB_BANKS));
  endfunction

  // bank-local word address, the bits right above the bank index
  function automatic mem_addr_t local_of(input addr_t a);
    return a[WORD_OFFSET_BITS + $clog2(NB_BANKS) +: ADDR_MEM_WIDTH];
  endfunction

  // per bank, first pending master at or after that bank's pointer
  function automatic logic [NB_MASTERS-1:0] expected_grant(input logic [NB_MASTERS-1:0] p);
    logic [NB_MASTERS-1:0] g;
    logic                  taken;
    int                    m;
    g = '0;
    for (int b = 0; b < NB_BANKS; b++) begin
      taken = 1'b0;
      for (int i = 0; i < NB_MASTERS; i++) begin
        m = (rr_ptr[b] + i) % NB_MASTERS;
        if (!taken && p[m] && bank_of(cur_add[m]) == b) begin
          g[m]  = 1'b1;
          taken = 1'b1;
        end
      end
    end
    return g;
  endfunction

  // **************************************************
  // compare tasks
  // **************************************************

  task automatic check_data(input data_t act, input data_t exp, input string what, input int p);
    if (act !== exp) begin
      $display("** Error at %0t: %s of port %0d is %08h, expected %08h",
               $time, what, p, act, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_grant(input logic [NB_MASTERS-1:0] act,
                             input logic [NB_MASTERS-1:0] exp, input string what);
    if (act !== exp) begin
      $display("** Error at %0t: %s is %b, expected %b", $time, what, act, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_bank(input logic [NB_BANKS-1:0] act, input logic [NB_BANKS-1:0] exp,
                            input string what);
    if (act !== exp) begin
      $display("** Error at %0t: %s is %b, expected %b", $time, what, act, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_mem_add(input mem_addr_t act, input mem_addr_t exp, input int b);
    if (act !== exp) begin
      $display("** Error at %0t: bank_add_o of bank %0d is %02h, expected %02h",
               $time, b, act, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_be(input be_t act, input be_t exp, input int b);
    if (act !== exp) begin
      $display("** Error at %0t: bank_be_o of bank %0d is %b, expected %b",
               $time, b, act, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // drive on the rising edge, check on the falling edge
  task automatic step_cycle();
    logic [NB_MASTERS-1:0] exp_gnt;
    logic [NB_BANKS-1:0]   exp_bank;
    logic [NB_BANKS-1:0]   exp_wen;
    int                    b;
    @(posedge clk);
    req   <= pend;
    add   <= cur_add;
    wen   <= cur_wen;
    wdata <= cur_wdata;
    be    <= cur_be;
    @(negedge clk);
    check_grant(r_valid, prev_acc, "r_valid_o");
    for (int m = 0; m < NB_MASTERS; m++) begin
      if (prev_acc[m] && prev_rd[m]) begin
        check_data(r_rdata[m], prev_exp[m], "r_rdata_o", m);
      end
    end
    exp_gnt  = expected_grant(pend);
    exp_bank = '0;
    exp_wen  = '0;
    for (int m = 0; m < NB_MASTERS; m++) begin
      if (pend[m]) begin
        exp_bank[bank_of(cur_add[m])] = 1'b1;
      end
      // the granted request must reach its bank port unchanged
      if (exp_gnt[m]) begin
        b = bank_of(cur_add[m]);
        exp_wen[b] = cur_wen[m];
        check_mem_add(bank_add[b], local_of(cur_add[m]), b);
        check_data(bank_wdata[b], cur_wdata[m], "bank_wdata_o", b);
        check_be(bank_be[b], cur_be[m], b);
        rr_ptr[b] = (m + 1) % NB_MASTERS;
        prev_exp[m] = cur_exp[m];
      end
    end
    check_grant(gnt, exp_gnt, "gnt_o");
    check_bank(bank_req, exp_bank, "bank_req_o");
    check_bank(bank_wen & exp_bank, exp_wen, "bank_wen_o");
    prev_rd  = cur_wen & exp_gnt;
    prev_acc = exp_gnt;
    pend     = pend & ~exp_gnt;
  endtask

  // **************************************************
  // main sequence
  // **************************************************

  initial begin : run_test
    int          idx;
    int          m;
    int          wait_cnt;
    int          gap;
    data_t       seq;
    clk = 1'b0;
    rst_n = 1'b0;
    req = '0;
    add = '0;
    wen = '0;
    wdata = '0;
    be = '0;
    pend = '0;
    cur_add = '0;
    cur_wen = '0;
    cur_wdata = '0;
    cur_be = '0;
    cur_exp = '0;
    prev_acc = '0;
    prev_rd = '0;
    prev_exp = '0;
    for (int b = 0; b < NB_BANKS; b++) begin
      rr_ptr[b] = 0;
    end
    void'($urandom(32'hf807));
    $readmemh("dv/tcdm_golden.txt", golden);
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    idx = 0;
    while (golden[idx] != 32'hffffffff) begin
      seq = golden[idx];
      while (golden[idx] == seq) begin
        m = int'(golden[idx + 1]);
        cur_wen[m]   = golden[idx + 2][0];
        cur_add[m]   = golden[idx + 3];
        cur_wdata[m] = golden[idx + 4];
        cur_be[m]    = be_t'(golden[idx + 5]);
        cur_exp[m]   = golden[idx + 6];
        pend[m]      = 1'b1;
        idx          = idx + 7;
      end
      wait_cnt = 0;
      while (pend != '0) begin
        if (wait_cnt == 20) begin
          $display("sequence %0d was still not fully granted after 20 cycles", seq);
          $display("Test failed");
          $fatal(1);
        end
        step_cycle();
        wait_cnt++;
      end
      gap = int'($urandom % 4);
      repeat (gap) step_cycle();
    end
    // collect the last responses
    step_cycle();
    step_cycle();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== dv/tcdm_sram_model.sv ====
// behavioral bank memories for the tcdm testbench, byte enables and one-cycle read latency
`timescale 1ns/1ns

module tcdm_sram_model #(
  parameter int unsigned NB_BANKS = tcdm_pkg::NB_BANKS_DEFAULT
) (
  input  logic                                clk_i,
  input  logic                [NB_BANKS-1:0]  req_i,
  input  tcdm_pkg::mem_addr_t [NB_BANKS-1:0]  add_i,
  input  logic                [NB_BANKS-1:0]  wen_i,
  input  tcdm_pkg::data_t     [NB_BANKS-1:0]  wdata_i,
  input  tcdm_pkg::be_t       [NB_BANKS-1:0]  be_i,
  output tcdm_pkg::data_t     [NB_BANKS-1:0]  rdata_o
);

  import tcdm_pkg::*;

  localparam int unsigned DEPTH = 2 ** ADDR_MEM_WIDTH;

  data_t mem [NB_BANKS][DEPTH];

  // fill pattern built from bank and word address
  initial begin
    rdata_o = '0;
    for (int b = 0; b < NB_BANKS; b++) begin
      for (int a = 0; a < DEPTH; a++) begin
        mem[b][a] = {8'hde, 8'(b), 8'(a), 8'hff ^ 8'(a)};
      end
    end
  end

  // wen high reads, low writes the enabled bytes
  always @(posedge clk_i) begin
    for (int b = 0; b < NB_BANKS; b++) begin
      if (req_i[b]) begin
        if (wen_i[b]) begin
          rdata_o[b] <= mem[b][add_i[b]];
        end else begin
          for (int k = 0; k < BE_WIDTH; k++) begin
            if (be_i[b][k]) begin
              mem[b][add_i[b]][8*k +: 8] <= wdata_i[b][8*k +: 8];
            end
          end
        end
      end
    end
  end

endmodule

// ==== tcdm_xbar/tcdm_interconnect.sv ====
// tcdm interconnect top, connects masters to word-interleaved banks through decoder, arbiters, router
`timescale 1ns/1ns

module tcdm_interconnect #(
  parameter int unsigned NB_MASTERS = tcdm_pkg::NB_MASTERS_DEFAULT,
  parameter int unsigned NB_BANKS   = tcdm_pkg::NB_BANKS_DEFAULT
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // master side
  input  logic                [NB_MASTERS-1:0]    req_i,
  input  tcdm_pkg::addr_t     [NB_MASTERS-1:0]    add_i,
  input  logic                [NB_MASTERS-1:0]    wen_i,
  input  tcdm_pkg::data_t     [NB_MASTERS-1:0]    wdata_i,
  input  tcdm_pkg::be_t       [NB_MASTERS-1:0]    be_i,
  output logic                [NB_MASTERS-1:0]    gnt_o,
  output logic                [NB_MASTERS-1:0]    r_valid_o,
  output tcdm_pkg::data_t     [NB_MASTERS-1:0]    r_rdata_o,
  // bank side, banks are always ready
  output logic                [NB_BANKS-1:0]      bank_req_o,
  output tcdm_pkg::mem_addr_t [NB_BANKS-1:0]      bank_add_o,
  output logic                [NB_BANKS-1:0]      bank_wen_o,
  output tcdm_pkg::data_t     [NB_BANKS-1:0]      bank_wdata_o,
  output tcdm_pkg::be_t       [NB_BANKS-1:0]      bank_be_o,
  input  tcdm_pkg::data_t     [NB_BANKS-1:0]      bank_rdata_i
);

  import tcdm_pkg::*;

  logic      [NB_BANKS-1:0][NB_MASTERS-1:0] dec_bank_req;
  mem_addr_t [NB_MASTERS-1:0]               dec_mem_add;
  logic      [NB_BANKS-1:0][NB_MASTERS-1:0] arb_gnt;

  tcdm_bank_if #(.NB_MASTERS(NB_MASTERS)) bank_if [NB_BANKS-1:0] ();

  tcdm_addr_decoder #(
    .NB_MASTERS (NB_MASTERS),
    .NB_BANKS   (NB_BANKS)
  ) u_decoder (
    .add_i      (add_i),
    .req_i      (req_i),
    .bank_req_o (dec_bank_req),
    .mem_add_o  (dec_mem_add)
  );

  // **************************************************
  // one arbiter per bank
  // **************************************************

  for (genvar b = 0; b < NB_BANKS; b++) begin : g_bank
    tcdm_bank_arbiter #(
      .NB_MASTERS (NB_MASTERS)
    ) u_arbiter (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .req_i     (dec_bank_req[b]),
      .mem_add_i (dec_mem_add),
      .wen_i     (wen_i),
      .wdata_i   (wdata_i),
      .be_i      (be_i),
      .gnt_o     (arb_gnt[b]),
      .bank      (bank_if[b])
    );

    assign bank_req_o[b]   = bank_if[b].req;
    assign bank_add_o[b]   = bank_if[b].add;
    assign bank_wen_o[b]   = bank_if[b].wen;
    assign bank_wdata_o[b] = bank_if[b].wdata;
    assign bank_be_o[b]    = bank_if[b].be;
  end

  // each master targets one bank, so at most one arbiter grants it
  always_comb begin
    gnt_o = '0;
    for (int b = 0; b < NB_BANKS; b++) begin
      gnt_o = gnt_o | arb_gnt[b];
    end
  end

  tcdm_resp_router #(
    .NB_MASTERS (NB_MASTERS),
    .NB_BANKS   (NB_BANKS)
  ) u_resp_router (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .bank         (bank_if),
    .bank_rdata_i (bank_rdata_i),
    .r_valid_o    (r_valid_o),
    .r_rdata_o    (r_rdata_o)
  );

  // a response always follows an accepted request by exactly one cycle
  for (genvar m = 0; m < NB_MASTERS; m++) begin : g_resp_chk
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      r_valid_o[m] |-> $past(req_i[m] && gnt_o[m]))
      else $error("master %0d got a response without an accepted request", m);
  end

endmodule

// ==== tcdm_xbar/tcdm_resp_router.sv ====
// response router, registers each bank's grant and returns valid and read data to its master
`timescale 1ns/1ns

module tcdm_resp_router #(
  parameter int unsigned NB_MASTERS = tcdm_pkg::NB_MASTERS_DEFAULT,
  parameter int unsigned NB_BANKS   = tcdm_pkg::NB_BANKS_DEFAULT
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  tcdm_bank_if.resp                           bank [NB_BANKS-1:0],
  input  tcdm_pkg::data_t [NB_BANKS-1:0]      bank_rdata_i,
  output logic            [NB_MASTERS-1:0]    r_valid_o,
  output tcdm_pkg::data_t [NB_MASTERS-1:0]    r_rdata_o
);

  import tcdm_pkg::*;

  localparam int unsigned ID_W = $clog2(NB_MASTERS);

  logic [NB_BANKS-1:0]                 bank_req;
  logic [NB_BANKS-1:0][ID_W-1:0]       bank_id;
  logic [NB_BANKS-1:0]                 rvalid_q;
  logic [NB_BANKS-1:0][ID_W-1:0]       rid_q;
  // hit[m][b] is set when bank b answers master m this cycle
  logic [NB_MASTERS-1:0][NB_BANKS-1:0] hit;

  for (genvar b = 0; b < NB_BANKS; b++) begin : g_bank
    assign bank_req[b] = bank[b].req;
    assign bank_id[b]  = bank[b].id;
  end

  // **************************************************
  // registered response id and valid per bank
  // **************************************************

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= '0;
      rid_q    <= '0;
    end else begin
      rvalid_q <= bank_req;
      for (int b = 0; b < NB_BANKS; b++) begin
        if (bank_req[b]) begin
          rid_q[b] <= bank_id[b];
        end
      end
    end
  end

  // **************************************************
  // steering back to the masters
  // **************************************************

  always_comb begin
    for (int m = 0; m < NB_MASTERS; m++) begin
      for (int b = 0; b < NB_BANKS; b++) begin
        hit[m][b] = rvalid_q[b] && (rid_q[b] == ID_W'(m));
      end
    end
  end

  // rdata is only meaningful for reads, writes return whatever the bank shows
  always_comb begin
    r_valid_o = '0;
    r_rdata_o = '0;
    for (int m = 0; m < NB_MASTERS; m++) begin
      for (int b = 0; b < NB_BANKS; b++) begin
        if (hit[m][b]) begin
          r_valid_o[m] = 1'b1;
          r_rdata_o[m] = bank_rdata_i[b];
        end
      end
    end
  end

  // a master sits on a single bank per cycle, so at most one bank answers it
  for (genvar m = 0; m < NB_MASTERS; m++) begin : g_chk
    assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(hit[m]))
      else $error("master %0d got a response from two banks", m);
  end

endmodule

// ==== tcdm_xbar/tcdm_bank_arbiter.sv ====
// round-robin arbiter of one bank, grants one master per cycle and drives that bank's request
`timescale 1ns/1ns

module tcdm_bank_arbiter #(
  parameter int unsigned NB_MASTERS = tcdm_pkg::NB_MASTERS_DEFAULT
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                [NB_MASTERS-1:0]    req_i,
  input  tcdm_pkg::mem_addr_t [NB_MASTERS-1:0]    mem_add_i,
  input  logic                [NB_MASTERS-1:0]    wen_i,
  input  tcdm_pkg::data_t     [NB_MASTERS-1:0]    wdata_i,
  input  tcdm_pkg::be_t       [NB_MASTERS-1:0]    be_i,
  output logic                [NB_MASTERS-1:0]    gnt_o,
  tcdm_bank_if.arb                                bank
);

  import tcdm_pkg::*;

  localparam int unsigned ID_W = $clog2(NB_MASTERS);

  // master with the highest priority in the current cycle
  logic [ID_W-1:0] rr_q;
  logic [ID_W-1:0] winner;
  logic            found;

  // **************************************************
  // winner selection
  // **************************************************

  // first requesting master at or after the pointer, wrapping around
  always_comb begin : pick_winner
    int idx;
    found  = 1'b0;
    winner = '0;
    for (int i = 0; i < NB_MASTERS; i++) begin
      idx = int'(rr_q) + i;
      if (idx >= NB_MASTERS) begin
        idx = idx - NB_MASTERS;
      end
      if (!found && req_i[idx]) begin
        found  = 1'b1;
        winner = ID_W'(idx);
      end
    end
  end

  always_comb begin
    for (int m = 0; m < NB_MASTERS; m++) begin
      gnt_o[m] = found && (winner == ID_W'(m));
    end
  end

  // pointer moves past the winner so it loses the next tie
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (found) begin
      if (winner == ID_W'(NB_MASTERS - 1)) begin
        rr_q <= '0;
      end else begin
        rr_q <= winner + 1'b1;
      end
    end
  end

  // **************************************************
  // bank side
  // **************************************************

  assign bank.req   = found;
  assign bank.add   = mem_add_i[winner];
  assign bank.wen   = wen_i[winner];
  assign bank.wdata = wdata_i[winner];
  assign bank.be    = be_i[winner];
  assign bank.id    = winner;

  // a single grant, only to a requester, and the bank busy whenever anyone requests
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0) && (bank.req == |req_i))
    else $error("bank arbiter granted more than one master, a non-requester or nobody");

endmodule

// ==== logic/tcdm_addr_decoder.sv ====
// address decoder, turns each master request into a request line toward its word-interleaved bank
`timescale 1ns/1ns

module tcdm_addr_decoder #(
  parameter int unsigned NB_MASTERS = tcdm_pkg::NB_MASTERS_DEFAULT,
  parameter int unsigned NB_BANKS   = tcdm_pkg::NB_BANKS_DEFAULT
) (
  input  tcdm_pkg::addr_t     [NB_MASTERS-1:0]               add_i,
  input  logic                [NB_MASTERS-1:0]               req_i,
  output logic                [NB_BANKS-1:0][NB_MASTERS-1:0] bank_req_o,
  output tcdm_pkg::mem_addr_t [NB_MASTERS-1:0]               mem_add_o
);

  import tcdm_pkg::*;

  // bank index width, zero with a single bank
  localparam int unsigned LOG_BANKS = $clog2(NB_BANKS);

  // word address per master, byte offset stripped
  addr_t [NB_MASTERS-1:0] word_add;

  // **************************************************
  // address split
  // **************************************************

  always_comb begin
    for (int m = 0; m < NB_MASTERS; m++) begin
      word_add[m] = add_i[m] >> WORD_OFFSET_BITS;
      // bits above the bank index, upper bits are dropped by the cast
      mem_add_o[m] = mem_addr_t'(word_add[m] >> LOG_BANKS);
    end
  end

  // **************************************************
  // bank request lines
  // **************************************************

  // consecutive words land in consecutive banks
  always_comb begin
    for (int b = 0; b < NB_BANKS; b++) begin
      for (int m = 0; m < NB_MASTERS; m++) begin
        bank_req_o[b][m] = req_i[m] &&
          ((word_add[m] & addr_t'(NB_BANKS - 1)) == addr_t'(b));
      end
    end
  end

endmodule

// ==== common/tcdm_bank_if.sv ====
// granted request of one bank, driven by its arbiter, read by the bank port and response router
`timescale 1ns/1ns

interface tcdm_bank_if #(
  parameter int unsigned NB_MASTERS = tcdm_pkg::NB_MASTERS_DEFAULT
);

  import tcdm_pkg::*;

  localparam int unsigned ID_W = $clog2(NB_MASTERS);

  logic            req;
  mem_addr_t       add;
  // high for read, low for write
  logic            wen;
  data_t           wdata;
  be_t             be;
  // index of the master that won this cycle
  logic [ID_W-1:0] id;

  modport arb (
    output req, add, wen, wdata, be, id
  );

  modport bank (
    input req, add, wen, wdata, be
  );

  // the router only needs to know who was granted
  modport resp (
    input req, id
  );

endinterface

// ==== common/tcdm_pkg.sv ====
// shared widths, address map and vector types of the tcdm interconnect, imported by all rtl
package tcdm_pkg;

  // **************************************************
  // word and address widths
  // **************************************************

  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;

  // **************************************************
  // address map
  // **************************************************

  // byte offset inside a word, the bank index sits right above it
  localparam int unsigned WORD_OFFSET_BITS = 2;

  // word address inside one bank, taken above the bank index
  localparam int unsigned ADDR_MEM_WIDTH = 8;

  // defaults handed to the top level parameters
  localparam int unsigned NB_MASTERS_DEFAULT = 4;
  localparam int unsigned NB_BANKS_DEFAULT   = 4;

  // **************************************************
  // vector types
  // **************************************************

  // one data word
  typedef logic [DATA_WIDTH-1:0] data_t;

  // byte address issued by a master
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // one enable per byte lane
  typedef logic [BE_WIDTH-1:0] be_t;

  // bank-local word address
  typedef logic [ADDR_MEM_WIDTH-1:0] mem_addr_t;

endpackage
